// ==== design/oadc_reg_pkg.sv ====
package oadc_reg_pkg;

   // register bus geometry
   localparam int BYTECNT_W = 7;
   localparam int FREQ_W    = 32;   // frequency and limit words

   // register map
   localparam logic [7:0] ADDR_GAIN      = 8'd0;   // r/w, 1 byte
   localparam logic [7:0] ADDR_SETTINGS  = 8'd1;   // r/w, 1 byte
   localparam logic [7:0] ADDR_STATUS    = 8'd2;   // read only
   localparam logic [7:0] ADDR_EXT_LIMIT = 8'd3;   // r/w, 4 bytes, lsb first
   localparam logic [7:0] ADDR_EXT_FREQ  = 8'd4;   // read only, 4 bytes

   // settings byte fields
   localparam int SET_LED_LSB = 0;
   localparam int SET_LED_MSB = 1;
   localparam int SET_MONDIS  = 2;   // monitor disable, clears the alarm

   // status byte fields
   localparam int STAT_TRIGGER = 0;
   localparam int STAT_PLL     = 1;
   localparam int STAT_EXTCHG  = 2;

   // multi-byte words are addressed as 4 consecutive bytes
   localparam int WORD_BYTES = FREQ_W / 8;

endpackage

// ==== design/oadc_clk_pkg.sv ====
package oadc_clk_pkg;

   // free-running timebase
   localparam int TB_W           = 14;
   localparam int MEASURE_BIT    = 10;   // rising edge ends a measurement window
   localparam int HEART_BIT      = 12;
   localparam int FLASH_GATE_BIT = 13;   // flash pattern only loads while this is set
   localparam int FLASH_BIT      = 11;

   // led select codes
   localparam logic [1:0] LED_NORMAL = 2'd0;
   localparam logic [1:0] LED_HEART  = 2'd1;
   localparam logic [1:0] LED_GAIN   = 2'd2;
   localparam logic [1:0] LED_ALARM  = 2'd3;

   // amplifier gain pwm
   localparam int PWM_W = 8;

endpackage

// ==== design/oadc_timebase.sv ====
`timescale 1ns/10ps

module oadc_timebase
   import oadc_clk_pkg::*;
(
   input  logic clk_usb,
   input  logic reset,
   output logic measure_pulse_o,
   output logic heartbeat_o,
   output logic flash_pattern_o
);

   logic [TB_W-1:0] tb_count;
   logic            measure_bit_r;   // last value of the window bit

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         tb_count        <= '0;
         measure_bit_r   <= 1'b0;
         measure_pulse_o <= 1'b0;
      end
      else begin
         tb_count        <= tb_count + 1'b1;
         measure_bit_r   <= tb_count[MEASURE_BIT];
         measure_pulse_o <= tb_count[MEASURE_BIT] & ~measure_bit_r;   // one per 2048 cycles
      end
   end

   // slow blink, frozen while the gate bit is low
   always_ff @(posedge clk_usb) begin
      if (reset)
         flash_pattern_o <= 1'b0;
      else if (tb_count[FLASH_GATE_BIT])
         flash_pattern_o <= ~tb_count[FLASH_BIT];
   end

   assign heartbeat_o = tb_count[HEART_BIT];

endmodule

// ==== design/oadc_freq_counter.sv ====
`timescale 1ns/10ps

module oadc_freq_counter
   import oadc_reg_pkg::*;
(
   input  logic              clk_usb,
   input  logic              reset,
   input  logic              ext_clk_i,
   input  logic              measure_pulse_i,
   input  logic              monitor_disable_i,
   input  logic [FREQ_W-1:0] ext_limit_i,
   output logic [FREQ_W-1:0] ext_frequency_o,
   output logic              ext_heartbeat_o,
   output logic              extclk_change_o
);

   logic              ext_sync1;
   logic              ext_sync2;
   logic              ext_sync3;   // edge detector history
   logic              ext_rise;
   logic [FREQ_W-1:0] run_count;
   logic [FREQ_W-1:0] freq_diff;
   logic              freq_jump;

   // ext clock is treated as plain data in the usb domain
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         ext_sync1 <= 1'b0;
         ext_sync2 <= 1'b0;
         ext_sync3 <= 1'b0;
      end
      else begin
         ext_sync1 <= ext_clk_i;
         ext_sync2 <= ext_sync1;
         ext_sync3 <= ext_sync2;
      end
   end

   assign ext_rise = ext_sync2 & ~ext_sync3;

   // distance between the new count and the last latched frequency
   always_comb begin
      if (ext_frequency_o > run_count)
         freq_diff = ext_frequency_o - run_count;
      else
         freq_diff = run_count - ext_frequency_o;
   end

   assign freq_jump = (ext_frequency_o != '0) && (freq_diff > ext_limit_i);

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         run_count       <= '0;
         ext_frequency_o <= '0;
      end
      else if (measure_pulse_i) begin
         ext_frequency_o <= run_count;
         run_count       <= FREQ_W'(ext_rise);   // an edge in this cycle opens the new window
      end
      else begin
         run_count <= run_count + FREQ_W'(ext_rise);
      end
   end

   // sticky until software sets monitor disable
   always_ff @(posedge clk_usb) begin
      if (reset || monitor_disable_i)
         extclk_change_o <= 1'b0;
      else if (measure_pulse_i && freq_jump)
         extclk_change_o <= 1'b1;
   end

   assign ext_heartbeat_o = run_count[4];

endmodule

// ==== design/oadc_regs.sv ====
`timescale 1ns/10ps

module oadc_regs
   import oadc_reg_pkg::*, oadc_clk_pkg::*;
(
   input  logic                 clk_usb,
   input  logic                 reset,
   input  logic [7:0]           reg_address_i,
   input  logic [BYTECNT_W-1:0] reg_bytecnt_i,
   input  logic [7:0]           reg_datai_i,
   input  logic                 reg_read_i,
   input  logic                 reg_write_i,
   output logic [7:0]           reg_datao_o,
   input  logic                 trigger_i,
   input  logic                 pll_status_i,
   input  logic                 extclk_change_i,
   input  logic [FREQ_W-1:0]    ext_frequency_i,
   output logic [PWM_W-1:0]     gain_o,
   output logic [1:0]           led_select_o,
   output logic                 monitor_disable_o,
   output logic [FREQ_W-1:0]    ext_limit_o
);

   logic [7:0]        settings_reg;
   logic [7:0]        status_byte;
   logic              word_byte_ok;   // bytecnt falls inside a 4 byte word
   logic [1:0]        byte_sel;

   assign byte_sel     = reg_bytecnt_i[1:0];
   assign word_byte_ok = (reg_bytecnt_i < BYTECNT_W'(WORD_BYTES));

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         gain_o       <= '0;
         settings_reg <= '0;
         ext_limit_o  <= '0;
      end
      else if (reg_write_i) begin
         case (reg_address_i)
            ADDR_GAIN:     gain_o       <= reg_datai_i;
            ADDR_SETTINGS: settings_reg <= reg_datai_i;
            ADDR_EXT_LIMIT: begin
               if (word_byte_ok)
                  ext_limit_o[byte_sel*8 +: 8] <= reg_datai_i;
            end
            default: ;   // read-only and unmapped addresses ignore writes
         endcase
      end
   end

   always_comb begin
      status_byte               = '0;
      status_byte[STAT_TRIGGER] = trigger_i;
      status_byte[STAT_PLL]     = pll_status_i;
      status_byte[STAT_EXTCHG]  = extclk_change_i;
   end

   // read mux, zero when idle or unmapped
   always_comb begin
      reg_datao_o = '0;
      if (reg_read_i) begin
         case (reg_address_i)
            ADDR_GAIN:     reg_datao_o = gain_o;
            ADDR_SETTINGS: reg_datao_o = settings_reg;
            ADDR_STATUS:   reg_datao_o = status_byte;
            ADDR_EXT_LIMIT: begin
               if (word_byte_ok)
                  reg_datao_o = ext_limit_o[byte_sel*8 +: 8];
            end
            ADDR_EXT_FREQ: begin
               if (word_byte_ok)
                  reg_datao_o = ext_frequency_i[byte_sel*8 +: 8];
            end
            default: reg_datao_o = '0;
         endcase
      end
   end

   assign led_select_o      = settings_reg[SET_LED_MSB:SET_LED_LSB];
   assign monitor_disable_o = settings_reg[SET_MONDIS];

endmodule

// ==== design/oadc_led_pwm.sv ====
`timescale 1ns/10ps

module oadc_led_pwm
   import oadc_clk_pkg::*;
(
   input  logic             clk_usb,
   input  logic             reset,
   input  logic [PWM_W-1:0] gain_i,
   input  logic [1:0]       led_select_i,
   input  logic             extclk_change_i,
   input  logic             flash_pattern_i,
   input  logic             heartbeat_i,
   input  logic             ext_heartbeat_i,
   input  logic             trigger_i,
   output logic             led_armed_o,
   output logic             led_capture_o,
   output logic             amp_gain_o
);

   logic [PWM_W:0] pwm_acc;   // top bit is the carry out

   // first order sigma-delta, gain high cycles out of every 256
   always_ff @(posedge clk_usb) begin
      if (reset)
         pwm_acc <= '0;
      else
         pwm_acc <= {1'b0, pwm_acc[PWM_W-1:0]} + {1'b0, gain_i};
   end

   assign amp_gain_o = pwm_acc[PWM_W];

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         led_armed_o   <= 1'b0;
         led_capture_o <= 1'b0;
      end
      else if (extclk_change_i) begin   // alarm overrides any selection
         led_armed_o   <= flash_pattern_i;
         led_capture_o <= flash_pattern_i;
      end
      else begin
         case (led_select_i)
            LED_HEART: begin
               led_armed_o   <= heartbeat_i;
               led_capture_o <= ext_heartbeat_i;
            end
            LED_GAIN: begin
               led_armed_o   <= amp_gain_o;
               led_capture_o <= 1'b0;
            end
            LED_ALARM: begin
               led_armed_o   <= 1'b0;
               led_capture_o <= extclk_change_i;
            end
            default: begin   // LED_NORMAL
               led_armed_o   <= trigger_i;
               led_capture_o <= 1'b0;
            end
         endcase
      end
   end

endmodule

// ==== design/oadc_interface_top.sv ====
`timescale 1ns/10ps

module oadc_interface_top
   import oadc_reg_pkg::*, oadc_clk_pkg::*;
(
   input  logic                 clk_usb,
   input  logic                 reset,
   input  logic [7:0]           reg_address_i,
   input  logic [BYTECNT_W-1:0] reg_bytecnt_i,
   input  logic [7:0]           reg_datai_i,
   output logic [7:0]           reg_datao_o,
   input  logic                 reg_read_i,
   input  logic                 reg_write_i,
   input  logic                 ext_clk_i,
   input  logic                 trigger_i,
   input  logic                 pll_status_i,
   output logic                 led_armed_o,
   output logic                 led_capture_o,
   output logic                 amp_gain_o
);

   logic              measure_pulse;
   logic              heartbeat;
   logic              flash_pattern;
   logic              ext_heartbeat;
   logic              monitor_disable;
   logic              extclk_change;
   logic [FREQ_W-1:0] ext_limit;
   logic [FREQ_W-1:0] ext_frequency;
   logic [PWM_W-1:0]  gain;
   logic [1:0]        led_select;

   oadc_timebase u_timebase (
      .clk_usb         (clk_usb),
      .reset           (reset),
      .measure_pulse_o (measure_pulse),
      .heartbeat_o     (heartbeat),
      .flash_pattern_o (flash_pattern)
   );

   oadc_freq_counter u_freq_counter (
      .clk_usb           (clk_usb),
      .reset             (reset),
      .ext_clk_i         (ext_clk_i),
      .measure_pulse_i   (measure_pulse),
      .monitor_disable_i (monitor_disable),
      .ext_limit_i       (ext_limit),
      .ext_frequency_o   (ext_frequency),
      .ext_heartbeat_o   (ext_heartbeat),
      .extclk_change_o   (extclk_change)
   );

   oadc_regs u_regs (
      .clk_usb           (clk_usb),
      .reset             (reset),
      .reg_address_i     (reg_address_i),
      .reg_bytecnt_i     (reg_bytecnt_i),
      .reg_datai_i       (reg_datai_i),
      .reg_read_i        (reg_read_i),
      .reg_write_i       (reg_write_i),
      .reg_datao_o       (reg_datao_o),
      .trigger_i         (trigger_i),
      .pll_status_i      (pll_status_i),
      .extclk_change_i   (extclk_change),
      .ext_frequency_i   (ext_frequency),
      .gain_o            (gain),
      .led_select_o      (led_select),
      .monitor_disable_o (monitor_disable),
      .ext_limit_o       (ext_limit)
   );

   oadc_led_pwm u_led_pwm (
      .clk_usb         (clk_usb),
      .reset           (reset),
      .gain_i          (gain),
      .led_select_i    (led_select),
      .extclk_change_i (extclk_change),
      .flash_pattern_i (flash_pattern),
      .heartbeat_i     (heartbeat),
      .ext_heartbeat_i (ext_heartbeat),
      .trigger_i       (trigger_i),
      .led_armed_o     (led_armed_o),
      .led_capture_o   (led_capture_o),
      .amp_gain_o      (amp_gain_o)
   );

endmodule

// ==== testbench/oadc_chk.sv ====
`timescale 1ns/10ps

module oadc_chk (
   input logic       clk_usb,
   input logic       reset,
   input logic       reg_read_i,
   input logic [7:0] reg_datao_i,
   input logic       led_armed_i,
   input logic       led_capture_i,
   input logic       amp_gain_i,
   input logic       extclk_change_i,
   input logic       monitor_disable_i
);

   int unsigned fail_count = 0;   // summed into the testbench summary

   reset_clears_outputs: assert property (@(posedge clk_usb)
      reset |=> !led_armed_i && !led_capture_i && !amp_gain_i)
   else begin
      fail_count++;
      $error("led or gain output not cleared in the cycle after reset");
   end

   // read bus is quiet between reads
   idle_read_zero: assert property (@(posedge clk_usb) disable iff (reset)
      !reg_read_i |-> reg_datao_i == 8'h00)
   else begin
      fail_count++;
      $error("read data not zero while no read is active");
   end

   no_alarm_when_disabled: assert property (@(posedge clk_usb) disable iff (reset)
      $rose(extclk_change_i) |-> !$past(monitor_disable_i))
   else begin
      fail_count++;
      $error("frequency change alarm rose while the monitor was disabled");
   end

endmodule

bind oadc_interface_top oadc_chk u_chk (
   .clk_usb           (clk_usb),
   .reset             (reset),
   .reg_read_i        (reg_read_i),
   .reg_datao_i       (reg_datao_o),
   .led_armed_i       (led_armed_o),
   .led_capture_i     (led_capture_o),
   .amp_gain_i        (amp_gain_o),
   .extclk_change_i   (extclk_change),
   .monitor_disable_i (monitor_disable)
);

// ==== testbench/tb_oadc.sv ====
`timescale 1ns/10ps

module tb_oadc
   import oadc_reg_pkg::*, oadc_clk_pkg::*;
;

   localparam int          CLK_PERIOD  = 100;
   localparam int          DRIVE_DLY   = 10;     // inputs change this long after the edge
   localparam int          WINDOW      = 2048;   // cycles per frequency window
   localparam int          RUN_WINDOWS = 12;
   localparam int          MARGIN      = 2000;
   localparam logic [31:0] SEED        = 32'h3ba7_b02f;

   logic                 clk_usb;
   logic                 reset;
   logic [7:0]           reg_address;
   logic [BYTECNT_W-1:0] reg_bytecnt;
   logic [7:0]           reg_datai;
   logic [7:0]           reg_datao;
   logic                 reg_read;
   logic                 reg_write;
   logic                 ext_clk;
   logic                 trigger;
   logic                 pll_status;
   logic                 led_armed;
   logic                 led_capture;
   logic                 amp_gain;

   int unsigned ext_half = 4;   // ext clock half period in clk_usb cycles
   int unsigned errors   = 0;

   oadc_interface_top dut (
      .clk_usb       (clk_usb),
      .reset         (reset),
      .reg_address_i (reg_address),
      .reg_bytecnt_i (reg_bytecnt),
      .reg_datai_i   (reg_datai),
      .reg_datao_o   (reg_datao),
      .reg_read_i    (reg_read),
      .reg_write_i   (reg_write),
      .ext_clk_i     (ext_clk),
      .trigger_i     (trigger),
      .pll_status_i  (pll_status),
      .led_armed_o   (led_armed),
      .led_capture_o (led_capture),
      .amp_gain_o    (amp_gain)
   );

   initial begin
      clk_usb = 1'b0;
      forever #(CLK_PERIOD/2) clk_usb = ~clk_usb;
   end

   // slow target clock, sampled as plain data by the dut
   initial begin
      ext_clk = 1'b0;
      forever begin
         repeat (ext_half) @(posedge clk_usb);
         #DRIVE_DLY ext_clk = ~ext_clk;
      end
   end

   task automatic step();
      @(posedge clk_usb);
      #DRIVE_DLY;
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp)
      else begin
         errors++;
         $display("Fail at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, got);
      end
   endtask

   task automatic check_range(input string name, input logic [31:0] got,
                              input logic [31:0] lo, input logic [31:0] hi);
      assert (got >= lo && got <= hi)
      else begin
         errors++;
         $display("Fail at %0t ns: %s expected %0d..%0d, got %0d", $time, name, lo, hi, got);
      end
   endtask

   task automatic write_reg(input logic [7:0] addr, input int cnt, input logic [7:0] data);
      reg_address = addr;
      reg_bytecnt = BYTECNT_W'(cnt);
      reg_datai   = data;
      reg_write   = 1'b1;
      step();
      reg_write = 1'b0;
   endtask

   task automatic read_reg(input logic [7:0] addr, input int cnt, output logic [7:0] data);
      reg_address = addr;
      reg_bytecnt = BYTECNT_W'(cnt);
      reg_read    = 1'b1;
      #(CLK_PERIOD/2 - DRIVE_DLY);   // mid cycle, read mux has settled
      data = reg_datao;
      step();
      reg_read = 1'b0;
   endtask

   task automatic write_word(input logic [7:0] addr, input logic [31:0] value);
      for (int b = 0; b < 4; b++)
         write_reg(addr, b, value[b*8 +: 8]);
   endtask

   task automatic read_word(input logic [7:0] addr, output logic [31:0] value);
      logic [7:0] rdata;
      for (int b = 0; b < 4; b++) begin
         read_reg(addr, b, rdata);
         value[b*8 +: 8] = rdata;
      end
   endtask

   // returns just after the latch edge of the next measurement pulse
   task automatic wait_window_end();
      step();
      while (!dut.measure_pulse)
         step();
      step();
   endtask

   initial begin
      logic [7:0]  rdata;
      logic [31:0] word;
      logic [7:0]  gain_val;
      int          ones;
      int unsigned exp_freq;
      reset       = 1'b1;
      reg_address = '0;
      reg_bytecnt = '0;
      reg_datai   = '0;
      reg_read    = 1'b0;
      reg_write   = 1'b0;
      trigger     = 1'b0;
      pll_status  = 1'b0;
      void'($urandom(SEED));
      repeat (5) @(posedge clk_usb);
      #DRIVE_DLY reset = 1'b0;

      // register readback, monitor kept disabled while the first windows settle
      write_reg(ADDR_SETTINGS, 0, 8'hF4);
      read_reg(ADDR_SETTINGS, 0, rdata);
      check_value("reg_datao_o settings", 32'(rdata), 32'h0000_00F4);
      write_reg(ADDR_GAIN, 0, 8'h5A);
      read_reg(ADDR_GAIN, 0, rdata);
      check_value("reg_datao_o gain", 32'(rdata), 32'h0000_005A);
      write_word(ADDR_EXT_LIMIT, 32'hC33C_5AA5);
      read_word(ADDR_EXT_LIMIT, word);
      check_value("reg_datao_o ext_limit", word, 32'hC33C_5AA5);
      write_word(ADDR_EXT_LIMIT, 32'd10);
      for (int i = 0; i < 4; i++) begin
         trigger    = i[0];
         pll_status = i[1];
         read_reg(ADDR_STATUS, 0, rdata);
         check_value("reg_datao_o status", 32'(rdata), 32'(i));
      end
      read_reg(8'h05, 0, rdata);
      check_value("reg_datao_o unmapped 0x05", 32'(rdata), 32'h0);
      read_reg(8'hFF, 0, rdata);
      check_value("reg_datao_o unmapped 0xff", 32'(rdata), 32'h0);

      // pwm duty over 256 cycles
      repeat (4) begin
         gain_val = 8'($urandom());
         write_reg(ADDR_GAIN, 0, gain_val);
         step();
         ones = 0;
         repeat (256) begin
            step();
            ones += int'(amp_gain);
         end
         check_value("amp_gain_o high cycles", 32'(ones), 32'(gain_val));
      end

      write_reg(ADDR_SETTINGS, 0, {5'b0, 1'b1, LED_NORMAL});
      repeat (6) begin
         trigger = ~trigger;
         step();
         check_value("led_armed_o", 32'(led_armed), 32'(trigger));
      end

      // second window end gives a full window at a steady rate
      wait_window_end();
      wait_window_end();
      exp_freq = WINDOW / (2 * ext_half);
      read_word(ADDR_EXT_FREQ, word);
      check_range("ext_frequency", word, exp_freq - 1, exp_freq + 1);

      // alarm on a jump beyond the limit, still clear right after enabling the monitor
      write_reg(ADDR_SETTINGS, 0, {6'b0, LED_ALARM});
      step();
      read_reg(ADDR_STATUS, 0, rdata);
      check_value("extclk_change", 32'(rdata[STAT_EXTCHG]), 32'h0);
      check_value("led_capture_o", 32'(led_capture), 32'h0);
      check_value("led_armed_o", 32'(led_armed), 32'h0);
      wait_window_end();
      read_reg(ADDR_STATUS, 0, rdata);
      check_value("extclk_change", 32'(rdata[STAT_EXTCHG]), 32'h0);
      ext_half = 2;
      wait_window_end();
      step();
      read_reg(ADDR_STATUS, 0, rdata);
      check_value("extclk_change", 32'(rdata[STAT_EXTCHG]), 32'h1);
      repeat (3) begin
         step();
         check_value("led_capture_o", 32'(led_capture), 32'(led_armed));
      end
      wait_window_end();
      read_reg(ADDR_STATUS, 0, rdata);
      check_value("extclk_change", 32'(rdata[STAT_EXTCHG]), 32'h1);
      write_reg(ADDR_SETTINGS, 0, {5'b0, 1'b1, LED_ALARM});
      step();
      read_reg(ADDR_STATUS, 0, rdata);
      check_value("extclk_change", 32'(rdata[STAT_EXTCHG]), 32'h0);

      // 512 back to 256 stays inside a wide limit
      write_word(ADDR_EXT_LIMIT, 32'd300);
      write_reg(ADDR_SETTINGS, 0, {6'b0, LED_ALARM});
      ext_half = 4;
      repeat (2) begin
         wait_window_end();
         read_reg(ADDR_STATUS, 0, rdata);
         check_value("extclk_change", 32'(rdata[STAT_EXTCHG]), 32'h0);
      end

      step();
      $display("failed checks: %0d, bound assertion failures: %0d", errors, dut.u_chk.fail_count);
      if (errors == 0 && dut.u_chk.fail_count == 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

   initial begin
      #((RUN_WINDOWS * WINDOW + MARGIN) * CLK_PERIOD);
      $display("watchdog expired, tests did not finish within %0d cycles",
               RUN_WINDOWS * WINDOW + MARGIN);
      $display("Simulation FAILED");
      $finish;
   end

endmodule

// ==== flist.f ====
design/oadc_reg_pkg.sv
design/oadc_clk_pkg.sv
design/oadc_timebase.sv
design/oadc_freq_counter.sv
design/oadc_regs.sv
design/oadc_led_pwm.sv
design/oadc_interface_top.sv
testbench/oadc_chk.sv
testbench/tb_oadc.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_oadc
FLIST     := flist.f
OBJDIR    := obj_dir
VFLAGS    := --timing --assert --timescale 1ns/10ps --top-module $(TOP) -f $(FLIST)
RUNFLAGS  := +verilator+error+limit+1000

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS)

sim:
	$(VERILATOR) --binary $(VFLAGS) --Mdir $(OBJDIR) -o $(TOP)
	@out="$$(./$(OBJDIR)/$(TOP) $(RUNFLAGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf $(OBJDIR)
